// ==== rtl/seg_pkg.sv ====
// ====================================================================
// Segmented bus geometry
// Widths and default layout of the segmented receive data bus
// ====================================================================

package seg_pkg;

    // ================================================================
    // Default bus layout
    // ================================================================

    // Segments per beat, power of two and at least 2
    localparam int DEFAULT_NUM_SEG = 2;

    // Data bits carried by one segment
    localparam int DEFAULT_SEG_W = 64;

    // ================================================================
    // Fixed encodings
    // ================================================================

    // One keep bit per byte lane
    // Keep width of a segment is SEG_W / BYTE_W
    localparam int BYTE_W = 8;

endpackage

// ==== rtl/flow_pkg.sv ====
// ====================================================================
// Flow control constants
// Credit counter width and default credit and buffer depths
// ====================================================================

package flow_pkg;

    // Width of every credit and fill counter, up to 31 credits
    localparam int CREDIT_W = 5;

    // Input FIFO depth in beats
    // Also the credits the sender holds after reset
    localparam int DEFAULT_IN_DEPTH = 4;

    // Credits granted by the downstream consumer after reset
    localparam int DEFAULT_OUT_CREDITS = 2;

endpackage

// ==== rtl/rx_in_buffer.sv ====
// ====================================================================
// Receive input buffer
// Circular FIFO of whole beats, filled against sender credits.
// Every popped beat returns one credit pulse to the sender.
// ====================================================================

`timescale 1ns/1ps

module rx_in_buffer #(
    parameter int NUM_SEG  = seg_pkg::DEFAULT_NUM_SEG,
    parameter int SEG_W    = seg_pkg::DEFAULT_SEG_W,
    parameter int IN_DEPTH = flow_pkg::DEFAULT_IN_DEPTH
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_valid,
    input  logic [NUM_SEG*SEG_W-1:0]                 in_data,
    input  logic [NUM_SEG*SEG_W/seg_pkg::BYTE_W-1:0] in_keep,
    input  logic [NUM_SEG-1:0]                       in_sop,
    input  logic [NUM_SEG-1:0]                       in_eop,
    output logic                                     in_credit,
    output logic                                     buf_valid,
    output logic [NUM_SEG*SEG_W-1:0]                 buf_data,
    output logic [NUM_SEG*SEG_W/seg_pkg::BYTE_W-1:0] buf_keep,
    output logic [NUM_SEG-1:0]                       buf_sop,
    output logic [NUM_SEG-1:0]                       buf_eop,
    input  logic                                     buf_ready
);

    localparam int DATA_W = NUM_SEG * SEG_W;
    localparam int KEEP_W = DATA_W / seg_pkg::BYTE_W;
    // Data, keep, sop and eop stored side by side
    localparam int BEAT_W = DATA_W + KEEP_W + 2 * NUM_SEG;
    localparam int PTR_W  = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;

    logic [BEAT_W-1:0]            mem [IN_DEPTH];
    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic [flow_pkg::CREDIT_W-1:0] fill;
    logic                         pop;

    // Head of the FIFO is shown as soon as it is written
    assign buf_valid = (fill != '0);
    assign pop       = buf_valid && buf_ready;
    assign {buf_data, buf_keep, buf_sop, buf_eop} = mem[rd_ptr];

    // Beat storage, overflow is excluded by the sender's credits
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= {in_data, in_keep, in_sop, in_eop};
        end
    end

    // Pointers wrap at IN_DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + flow_pkg::CREDIT_W'(in_valid) - flow_pkg::CREDIT_W'(pop);
            // One credit back per popped beat, one cycle later
            in_credit <= pop;
        end
    end

endmodule

// ==== rtl/rx_seg_align.sv ====
// ====================================================================
// Receive segment aligner
// Keeps a two-beat window of segments and emits one packet run per
// output beat, shifted so that the run starts in segment 0
// ====================================================================

`timescale 1ns/1ps

module rx_seg_align #(
    parameter int NUM_SEG = seg_pkg::DEFAULT_NUM_SEG,
    parameter int SEG_W   = seg_pkg::DEFAULT_SEG_W
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     buf_valid,
    input  logic [NUM_SEG*SEG_W-1:0]                 buf_data,
    input  logic [NUM_SEG*SEG_W/seg_pkg::BYTE_W-1:0] buf_keep,
    input  logic [NUM_SEG-1:0]                       buf_sop,
    input  logic [NUM_SEG-1:0]                       buf_eop,
    output logic                                     buf_ready,
    output logic                                     aln_valid,
    output logic [NUM_SEG*SEG_W-1:0]                 aln_data,
    output logic [NUM_SEG*SEG_W/seg_pkg::BYTE_W-1:0] aln_keep,
    output logic [NUM_SEG-1:0]                       aln_sop,
    output logic                                     aln_last,
    input  logic                                     aln_ready
);

    localparam int WIN_SEG    = 2 * NUM_SEG;
    localparam int SEG_KEEP_W = SEG_W / seg_pkg::BYTE_W;
    localparam int IDX_W      = $clog2(NUM_SEG);

    // ================================================================
    // Work window, low half is segments 0 to NUM_SEG-1
    // ================================================================

    logic [WIN_SEG-1:0][SEG_W-1:0]      win_data;
    logic [WIN_SEG-1:0][SEG_KEEP_W-1:0] win_keep;
    logic [WIN_SEG-1:0]                 win_sop;
    logic [WIN_SEG-1:0]                 win_eop;
    logic [WIN_SEG-1:0]                 occ;

    // Segment holds something when its first byte is kept or a header starts
    for (genvar i = 0; i < WIN_SEG; i++) begin : g_occ
        assign occ[i] = win_keep[i][0] || win_sop[i];
    end

    // ================================================================
    // Run selection
    // ================================================================

    logic                 found;
    logic                 stopped;
    logic                 run_full;
    logic                 run_last;
    logic [IDX_W-1:0]     start_idx;
    logic [WIN_SEG-1:0]   run_mask;
    logic [NUM_SEG-1:0]   out_mask;

    always_comb begin
        found     = 1'b0;
        stopped   = 1'b0;
        run_full  = 1'b0;
        run_last  = 1'b0;
        start_idx = '0;
        run_mask  = '0;
        out_mask  = '0;
        for (int i = 0; i < NUM_SEG; i++) begin
            // First occupied low segment opens the run
            if (!found && occ[i]) begin
                found     = 1'b1;
                start_idx = IDX_W'(i);
                run_full  = 1'b1;
                for (int j = 0; j < NUM_SEG; j++) begin
                    // Run closes after an end or before the next header
                    if (j > 0 && (win_sop[i + j] || run_last)) begin
                        stopped = 1'b1;
                    end
                    if (stopped) begin
                        run_full = 1'b0;
                    end else begin
                        run_mask[i + j] = 1'b1;
                        out_mask[j]     = 1'b1;
                        run_full        = run_full && occ[i + j];
                        run_last        = run_last || win_eop[i + j];
                    end
                end
            end
        end
    end

    // Complete when it ends a packet or fills a whole beat
    assign aln_valid = found && (run_last || run_full);
    assign aln_last  = run_last;

    // Move the run down to segment 0, unused lanes carry no keep
    logic [NUM_SEG-1:0][SEG_W-1:0]      out_seg_data;
    logic [NUM_SEG-1:0][SEG_KEEP_W-1:0] out_seg_keep;

    always_comb begin
        aln_sop = '0;
        aln_sop[0] = win_sop[start_idx];
        for (int k = 0; k < NUM_SEG; k++) begin
            out_seg_data[k] = win_data[int'(start_idx) + k];
            out_seg_keep[k] = out_mask[k] ? win_keep[int'(start_idx) + k] : '0;
        end
    end

    assign aln_data = out_seg_data;
    assign aln_keep = out_seg_keep;

    // ================================================================
    // Window update
    // ================================================================

    logic               fire;
    logic               shift;
    logic               accept;
    logic [WIN_SEG-1:0] emit_mask;
    logic [NUM_SEG-1:0] low_left;

    assign fire      = aln_valid && aln_ready;
    assign emit_mask = fire ? run_mask : '0;
    // Low half drains once nothing unsent is left in it
    assign low_left  = occ[NUM_SEG-1:0] & ~emit_mask[NUM_SEG-1:0];
    assign shift     = ~|low_left;
    assign buf_ready = shift || ~|occ[WIN_SEG-1:NUM_SEG];
    assign accept    = buf_valid && buf_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_keep <= '0;
            win_sop  <= '0;
            win_eop  <= '0;
        end else begin
            // Sent low segments go empty, another header may still follow
            for (int i = 0; i < NUM_SEG; i++) begin
                if (emit_mask[i]) begin
                    win_keep[i] <= '0;
                    win_sop[i]  <= 1'b0;
                    win_eop[i]  <= 1'b0;
                end
            end
            if (shift) begin
                win_keep[0 +: NUM_SEG]       <= win_keep[NUM_SEG +: NUM_SEG];
                win_sop[0 +: NUM_SEG]        <= win_sop[NUM_SEG +: NUM_SEG];
                win_eop[0 +: NUM_SEG]        <= win_eop[NUM_SEG +: NUM_SEG];
                win_keep[NUM_SEG +: NUM_SEG] <= '0;
                win_sop[NUM_SEG +: NUM_SEG]  <= '0;
                win_eop[NUM_SEG +: NUM_SEG]  <= '0;
                // High segments sent this cycle must not reappear below
                for (int i = 0; i < NUM_SEG; i++) begin
                    if (emit_mask[NUM_SEG + i]) begin
                        win_keep[i] <= '0;
                        win_sop[i]  <= 1'b0;
                        win_eop[i]  <= 1'b0;
                    end
                end
            end
            // New beat always lands in the high half
            if (accept) begin
                win_keep[NUM_SEG +: NUM_SEG] <= buf_keep;
                win_sop[NUM_SEG +: NUM_SEG]  <= buf_sop;
                win_eop[NUM_SEG +: NUM_SEG]  <= buf_eop;
            end
        end
    end

    // Payload follows the same moves, stale words are masked by keep
    always_ff @(posedge clk) begin
        if (shift) begin
            win_data[0 +: NUM_SEG] <= win_data[NUM_SEG +: NUM_SEG];
        end
        if (accept) begin
            win_data[NUM_SEG +: NUM_SEG] <= buf_data;
        end
    end

endmodule

// ==== rtl/rx_out_credit.sv ====
// ====================================================================
// Receive output stage
// Registers aligned beats and sends them while downstream credits last
// ====================================================================

`timescale 1ns/1ps

module rx_out_credit #(
    parameter int NUM_SEG     = seg_pkg::DEFAULT_NUM_SEG,
    parameter int SEG_W       = seg_pkg::DEFAULT_SEG_W,
    parameter int OUT_CREDITS = flow_pkg::DEFAULT_OUT_CREDITS
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     aln_valid,
    input  logic [NUM_SEG*SEG_W-1:0]                 aln_data,
    input  logic [NUM_SEG*SEG_W/seg_pkg::BYTE_W-1:0] aln_keep,
    input  logic [NUM_SEG-1:0]                       aln_sop,
    input  logic                                     aln_last,
    output logic                                     aln_ready,
    output logic                                     out_valid,
    output logic [NUM_SEG*SEG_W-1:0]                 out_data,
    output logic [NUM_SEG*SEG_W/seg_pkg::BYTE_W-1:0] out_keep,
    output logic [NUM_SEG-1:0]                       out_sop,
    output logic                                     out_last,
    input  logic                                     out_credit
);

    logic [flow_pkg::CREDIT_W-1:0] credits;
    logic                          fire;

    // Take a beat only while a downstream credit is held
    assign aln_ready = (credits != '0);
    assign fire      = aln_valid && aln_ready;

    // Spend and return can land in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits   <= flow_pkg::CREDIT_W'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            credits   <= credits - flow_pkg::CREDIT_W'(fire)
                                 + flow_pkg::CREDIT_W'(out_credit);
            // Valid for exactly one cycle per accepted beat
            out_valid <= fire;
        end
    end

    // Beat fields hold until the next accepted beat
    always_ff @(posedge clk) begin
        if (fire) begin
            out_data <= aln_data;
            out_keep <= aln_keep;
            out_sop  <= aln_sop;
            out_last <= aln_last;
        end
    end

endmodule

// ==== rtl/rx_align_top.sv ====
// ====================================================================
// Receive alignment top level
// Input buffer, segment aligner and credited output stage in a chain
// ====================================================================

`timescale 1ns/1ps

module rx_align_top #(
    parameter int NUM_SEG     = seg_pkg::DEFAULT_NUM_SEG,
    parameter int SEG_W       = seg_pkg::DEFAULT_SEG_W,
    parameter int IN_DEPTH    = flow_pkg::DEFAULT_IN_DEPTH,
    parameter int OUT_CREDITS = flow_pkg::DEFAULT_OUT_CREDITS
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // Sender side
    input  logic                                     in_valid,
    input  logic [NUM_SEG*SEG_W-1:0]                 in_data,
    input  logic [NUM_SEG*SEG_W/seg_pkg::BYTE_W-1:0] in_keep,
    input  logic [NUM_SEG-1:0]                       in_sop,
    input  logic [NUM_SEG-1:0]                       in_eop,
    output logic                                     in_credit,
    // Consumer side
    output logic                                     out_valid,
    output logic [NUM_SEG*SEG_W-1:0]                 out_data,
    output logic [NUM_SEG*SEG_W/seg_pkg::BYTE_W-1:0] out_keep,
    output logic [NUM_SEG-1:0]                       out_sop,
    output logic                                     out_last,
    input  logic                                     out_credit
);

    localparam int DATA_W = NUM_SEG * SEG_W;
    localparam int KEEP_W = DATA_W / seg_pkg::BYTE_W;

    // Buffer to aligner
    logic              buf_valid;
    logic              buf_ready;
    logic [DATA_W-1:0] buf_data;
    logic [KEEP_W-1:0] buf_keep;
    logic [NUM_SEG-1:0] buf_sop;
    logic [NUM_SEG-1:0] buf_eop;

    // Aligner to output stage
    logic              aln_valid;
    logic              aln_ready;
    logic [DATA_W-1:0] aln_data;
    logic [KEEP_W-1:0] aln_keep;
    logic [NUM_SEG-1:0] aln_sop;
    logic              aln_last;

    rx_in_buffer #(
        .NUM_SEG(NUM_SEG), .SEG_W(SEG_W), .IN_DEPTH(IN_DEPTH)
    ) rx_in_buffer_inst (
        .clk, .rst_n,
        .in_valid, .in_data, .in_keep, .in_sop, .in_eop, .in_credit,
        .buf_valid, .buf_data, .buf_keep, .buf_sop, .buf_eop, .buf_ready
    );

    rx_seg_align #(
        .NUM_SEG(NUM_SEG), .SEG_W(SEG_W)
    ) rx_seg_align_inst (
        .clk, .rst_n,
        .buf_valid, .buf_data, .buf_keep, .buf_sop, .buf_eop, .buf_ready,
        .aln_valid, .aln_data, .aln_keep, .aln_sop, .aln_last, .aln_ready
    );

    rx_out_credit #(
        .NUM_SEG(NUM_SEG), .SEG_W(SEG_W), .OUT_CREDITS(OUT_CREDITS)
    ) rx_out_credit_inst (
        .clk, .rst_n,
        .aln_valid, .aln_data, .aln_keep, .aln_sop, .aln_last, .aln_ready,
        .out_valid, .out_data, .out_keep, .out_sop, .out_last, .out_credit
    );

endmodule

// ==== bench/tb_rx_align.sv ====
// ======================================================================
// Receive aligner testbench
// LFSR packet source, credit-keeping sender and consumer, scoreboard
// and assertions around the aligned receive pipeline
// ======================================================================

`timescale 1ns/1ps

module tb_rx_align;

    localparam int NUM_SEG     = seg_pkg::DEFAULT_NUM_SEG;
    localparam int SEG_W       = seg_pkg::DEFAULT_SEG_W;
    localparam int IN_DEPTH    = flow_pkg::DEFAULT_IN_DEPTH;
    localparam int OUT_CREDITS = flow_pkg::DEFAULT_OUT_CREDITS;
    localparam int SEG_KW      = SEG_W / seg_pkg::BYTE_W;
    localparam int KEEP_W      = NUM_SEG * SEG_KW;
    // Stored segment layout is {sop, eop, keep, data}
    localparam int SEG_E       = SEG_W + SEG_KW + 2;
    localparam int TIMEOUT     = 2000;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic [NUM_SEG*SEG_W-1:0] in_data;
    logic [KEEP_W-1:0]        in_keep;
    logic [NUM_SEG-1:0]       in_sop;
    logic [NUM_SEG-1:0]       in_eop;
    logic                     in_credit;
    logic                     out_valid;
    logic [NUM_SEG*SEG_W-1:0] out_data;
    logic [KEEP_W-1:0]        out_keep;
    logic [NUM_SEG-1:0]       out_sop;
    logic                     out_last;
    logic                     out_credit;

    // Segment stream for the sender including idle segments
    logic [SEG_E-1:0] stream_q[$];
    // Packet segments in the order they must come out
    logic [SEG_E-1:0] expect_q[$];
    logic [31:0]      lfsr;
    logic             withhold;
    int               errors;
    int               checks;
    int               tests;
    int               send_credits;
    int               sent_beats;
    int               in_pulses;
    int               out_beats;
    int               credits_ret;
    int               owed;
    int               two_start_beats;
    int               end_gap_beats;

    rx_align_top #(
        .NUM_SEG(NUM_SEG), .SEG_W(SEG_W), .IN_DEPTH(IN_DEPTH), .OUT_CREDITS(OUT_CREDITS)
    ) rx_align_top_inst (
        .clk, .rst_n,
        .in_valid, .in_data, .in_keep, .in_sop, .in_eop, .in_credit,
        .out_valid, .out_data, .out_keep, .out_sop, .out_last, .out_credit
    );

    always #50 clk = ~clk;

    // ==================================================================
    // Helpers
    // ==================================================================

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Lane is in use when its first byte is kept or a header starts there
    function automatic logic [NUM_SEG-1:0] lanes_used(input logic [KEEP_W-1:0] keep,
                                                      input logic [NUM_SEG-1:0] sop);
        logic [NUM_SEG-1:0] m;
        for (int k = 0; k < NUM_SEG; k++) begin
            m[k] = keep[k*SEG_KW] || sop[k];
        end
        return m;
    endfunction

    // True for masks of the form 0..011..1 with bit 0 set
    function automatic logic packed_from_zero(input logic [NUM_SEG-1:0] m);
        logic [NUM_SEG-1:0] m_inc;
        m_inc = m + 1'b1;
        return m[0] && ((m_inc & m) == '0);
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] want,
                                   input logic [63:0] got);
        errors++;
        $display("FAILED t=%0t %s expected %0h actual %0h", $time, name, want, got);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic expect_equal(input string name, input logic [63:0] want,
                                input logic [63:0] got);
        checks++;
        assert (got === want) else report_mismatch(name, want, got);
    endtask

    task automatic end_test(input string name, input int mark);
        tests++;
        $display("test %s finished with %0d errors", name, errors - mark);
    endtask

    // ==================================================================
    // Packet source
    // ==================================================================

    task automatic push_idle();
        stream_q.push_back('0);
    endtask

    // Full keep except a ragged last segment
    task automatic push_packet(input int len);
        logic [SEG_KW-1:0] keep;
        logic [SEG_W-1:0]  data;
        logic [SEG_E-1:0]  seg;
        for (int i = 0; i < len; i++) begin
            data = SEG_W'({take_bits(32), take_bits(32)});
            keep = (i == len - 1) ? ({SEG_KW{1'b1}} >> take_bits(3)) : '1;
            seg  = {i == 0, i == len - 1, keep, data};
            stream_q.push_back(seg);
            expect_q.push_back(seg);
        end
    endtask

    // Lengths 1 to 5 with an idle segment before about one packet in four
    task automatic push_random(input int count);
        for (int p = 0; p < count; p++) begin
            if (take_bits(2) == 0) begin
                push_idle();
            end
            push_packet(1 + int'(take_bits(3) % 5));
        end
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while ((stream_q.size() != 0 || expect_q.size() != 0) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stream_q.size() != 0 || expect_q.size() != 0) begin
            report_problem($sformatf("timeout, %s did not drain", what));
        end
    endtask

    // ==================================================================
    // Sender and consumer on the falling edge
    // ==================================================================

    // Packs the stream into beats at one credit per beat
    always @(negedge clk) begin
        logic [SEG_E-1:0] seg;
        in_valid = 1'b0;
        if (rst_n) begin
            if (in_credit) begin
                in_pulses++;
                send_credits++;
            end
            if (send_credits > 0 && stream_q.size() != 0) begin
                for (int k = 0; k < NUM_SEG; k++) begin
                    // Short tail is padded with idle segments
                    seg = (stream_q.size() != 0) ? stream_q.pop_front() : '0;
                    in_data[k*SEG_W +: SEG_W]  = seg[SEG_W-1:0];
                    in_keep[k*SEG_KW +: SEG_KW] = seg[SEG_W +: SEG_KW];
                    in_eop[k] = seg[SEG_E-2];
                    in_sop[k] = seg[SEG_E-1];
                end
                in_valid = 1'b1;
                send_credits--;
                sent_beats++;
                // Mixed beat coverage
                if ($countones(in_sop) >= 2) begin
                    two_start_beats++;
                end
                if (|(in_eop[NUM_SEG-2:0] & ~lanes_used(in_keep, in_sop) >> 1)) begin
                    end_gap_beats++;
                end
            end
        end
    end

    // Scoreboard compare and random credit return
    always @(negedge clk) begin
        logic [NUM_SEG-1:0] used;
        logic [SEG_E-1:0]   want;
        logic               last_eop;
        out_credit = 1'b0;
        if (rst_n) begin
            if (out_valid) begin
                out_beats++;
                owed++;
                used     = lanes_used(out_keep, out_sop);
                last_eop = 1'b0;
                for (int k = 0; k < NUM_SEG; k++) begin
                    if (used[k] && expect_q.size() == 0) begin
                        report_problem("output segment arrived with no packet left to match");
                    end else if (used[k]) begin
                        want = expect_q.pop_front();
                        expect_equal($sformatf("out_data seg %0d", k), want[SEG_W-1:0],
                                     out_data[k*SEG_W +: SEG_W]);
                        expect_equal($sformatf("out_keep seg %0d", k), want[SEG_W +: SEG_KW],
                                     out_keep[k*SEG_KW +: SEG_KW]);
                        expect_equal($sformatf("out_sop seg %0d", k), want[SEG_E-1], out_sop[k]);
                        last_eop = want[SEG_E-2];
                    end
                end
                expect_equal("out_last", last_eop, out_last);
            end
            if (!withhold && owed > 0 && take_bits(1) == 1) begin
                out_credit = 1'b1;
                owed--;
                credits_ret++;
            end
        end
    end

    // ==================================================================
    // Assertions
    // ==================================================================

    reset_out_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else report_mismatch("out_valid", 64'd0, $sampled(out_valid));
    reset_in_credit: assert property (@(posedge clk) !rst_n |=> !in_credit)
        else report_mismatch("in_credit", 64'd0, $sampled(in_credit));
    // First cycle out of reset stays quiet too
    reset_exit_quiet: assert property (@(posedge clk) $rose(rst_n) |=> !out_valid && !in_credit)
        else report_mismatch("out_valid,in_credit", 64'd0, {$sampled(out_valid),
                                                            $sampled(in_credit)});
    sop_in_seg0: assert property (@(posedge clk) out_valid |-> out_sop[NUM_SEG-1:1] == '0)
        else report_mismatch("out_sop above segment 0", 64'd0, $sampled(out_sop) >> 1);
    lanes_from_zero: assert property (@(posedge clk)
        out_valid |-> packed_from_zero(lanes_used(out_keep, out_sop)))
        else report_problem("kept segments are not packed down from segment 0");
    // Beat that does not end a packet carries a full run
    open_beat_full: assert property (@(posedge clk)
        out_valid && !out_last |-> lanes_used(out_keep, out_sop) == '1)
        else report_mismatch("out_keep lanes", {NUM_SEG{1'b1}},
                             lanes_used($sampled(out_keep), $sampled(out_sop)));
    out_credit_limit: assert property (@(posedge clk)
        rst_n |-> out_beats - credits_ret <= OUT_CREDITS)
        else report_problem("out_valid beats exceed the credits granted downstream");
    in_credit_limit: assert property (@(posedge clk)
        rst_n |-> in_pulses <= sent_beats)
        else report_problem("in_credit returned more credits than beats were sent");

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin
        int mark;
        int n;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_keep      = '0;
        in_sop       = '0;
        in_eop       = '0;
        out_credit   = 1'b0;
        withhold     = 1'b0;
        lfsr         = 32'hb61e8f27;
        send_credits = IN_DEPTH;

        // Reset held for 3 cycles and released on a falling edge
        mark = errors;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        end_test("reset", mark);

        mark = errors;
        @(posedge clk);
        push_random(40);
        wait_drain("random traffic");
        end_test("random traffic", mark);

        // Consumer holds its credits back so the pipe stalls at the limit
        mark     = errors;
        @(posedge clk);
        withhold = 1'b1;
        push_random(10);
        n = 0;
        while (owed < OUT_CREDITS && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (owed < OUT_CREDITS) begin
            report_problem("output stage never used up its credits");
        end
        repeat (20) @(posedge clk);
        expect_equal("unreturned out_valid beats", OUT_CREDITS, owed);
        withhold = 1'b0;
        wait_drain("withheld traffic");
        end_test("credit withhold", mark);

        // Stream starts on a beat boundary here so beat 0 holds two starts
        // and beat 2 holds an end followed by an empty segment
        mark = errors;
        @(posedge clk);
        push_packet(1);
        push_packet(3);
        push_packet(1);
        push_idle();
        push_packet(2);
        push_random(20);
        wait_drain("mixed beats");
        assert (two_start_beats > 0) else report_problem("no beat with two starts was sent");
        assert (end_gap_beats > 0) else report_problem("no beat with an end then a gap was sent");
        end_test("mixed beats", mark);

        // Every beat sent must come back as one in_credit pulse
        mark = errors;
        n    = 0;
        while ((in_pulses != sent_beats || owed != 0) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        expect_equal("in_credit pulses", sent_beats, in_pulses);
        expect_equal("sender credits", IN_DEPTH, send_credits);
        end_test("credit return", mark);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/seg_pkg.sv
rtl/flow_pkg.sv
rtl/rx_in_buffer.sv
rtl/rx_seg_align.sv
rtl/rx_out_credit.sv
rtl/rx_align_top.sv
bench/tb_rx_align.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the receive aligner testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_align -f vlog.f \
    && ./obj_dir/Vtb_rx_align | tee sim.log \
    && grep -qx "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
